// ==== exec_pkg.sv ====
package exec_pkg;

    // alu operation codes, numbered as in the alu table
    typedef enum logic [4:0] {
        op_add        = 5'd0,
        op_sub        = 5'd1,
        op_sll        = 5'd2,
        op_slt        = 5'd3,
        op_sltu       = 5'd4,
        op_xor        = 5'd5,
        op_srl        = 5'd6,
        op_sra        = 5'd7,
        op_or         = 5'd8,
        op_and        = 5'd9,
        // compares only set the condition flag
        op_beq        = 5'd10,
        op_bne        = 5'd11,
        op_blt        = 5'd12,
        op_bge        = 5'd13,
        op_bltu       = 5'd14,
        op_bgeu       = 5'd15,
        // lui passes in2 through
        op_lui        = 5'd16,
        op_mul        = 5'd17,
        op_mulh       = 5'd18,
        op_mulhsu     = 5'd19,
        op_mulhu      = 5'd20,
        // counter reads
        op_rdinstreth = 5'd21,
        op_rdinstret  = 5'd22,
        op_rdcycleh   = 5'd23,
        op_rdcycle    = 5'd24
    } alu_op_e;

    // one decoded operation as it sits in the fifo
    typedef struct packed {
        alu_op_e     op;
        logic [31:0] in1;
        logic [31:0] in2;
        // zero for branches
        logic [4:0]  rd;
    } exec_op_t;

    // execute result, taken is the alu zero flag
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        taken;
    } exec_result_t;

    // user-level counter csr addresses
    localparam logic [11:0] csr_cycle    = 12'hC00;
    localparam logic [11:0] csr_cycleh   = 12'hC80;
    localparam logic [11:0] csr_instret  = 12'hC02;
    localparam logic [11:0] csr_instreth = 12'hC82;

endpackage

// ==== instr_decode.sv ====
`timescale 1ns/100ps

module instr_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    input  logic [31:0]         rs1_val,
    input  logic [31:0]         rs2_val,
    output logic                op_write,
    output exec_pkg::exec_op_t  op,
    output logic                illegal
);

    // rv32 instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;

    logic               legal;
    exec_pkg::exec_op_t dec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    always_comb begin
        legal   = 1'b0;
        dec.op  = exec_pkg::op_add;
        dec.in1 = rs1_val;
        dec.in2 = rs2_val;
        dec.rd  = instr[11:7];
        case (opcode)
            // OP, register-register
            7'b0110011: begin
                legal = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'd0: dec.op = exec_pkg::op_add;
                        3'd1: dec.op = exec_pkg::op_sll;
                        3'd2: dec.op = exec_pkg::op_slt;
                        3'd3: dec.op = exec_pkg::op_sltu;
                        3'd4: dec.op = exec_pkg::op_xor;
                        3'd5: dec.op = exec_pkg::op_srl;
                        3'd6: dec.op = exec_pkg::op_or;
                        default: dec.op = exec_pkg::op_and;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'd0) begin
                    dec.op = exec_pkg::op_sub;
                end else if (funct7 == 7'b0100000 && funct3 == 3'd5) begin
                    dec.op = exec_pkg::op_sra;
                end else if (funct7 == 7'b0000001 && funct3 == 3'd0) begin
                    dec.op = exec_pkg::op_mul;
                end else if (funct7 == 7'b0000001 && funct3 == 3'd1) begin
                    dec.op = exec_pkg::op_mulh;
                end else if (funct7 == 7'b0000001 && funct3 == 3'd2) begin
                    dec.op = exec_pkg::op_mulhsu;
                end else if (funct7 == 7'b0000001 && funct3 == 3'd3) begin
                    dec.op = exec_pkg::op_mulhu;
                end else begin
                    // div/rem and unknown funct7
                    legal = 1'b0;
                end
            end
            // OP-IMM
            7'b0010011: begin
                legal   = 1'b1;
                dec.in2 = imm_i;
                case (funct3)
                    3'd0: dec.op = exec_pkg::op_add;
                    3'd2: dec.op = exec_pkg::op_slt;
                    3'd3: dec.op = exec_pkg::op_sltu;
                    3'd4: dec.op = exec_pkg::op_xor;
                    3'd6: dec.op = exec_pkg::op_or;
                    3'd7: dec.op = exec_pkg::op_and;
                    3'd1: begin
                        // slli, shamt from the instruction
                        dec.op  = exec_pkg::op_sll;
                        dec.in2 = {27'b0, instr[24:20]};
                        legal   = (funct7 == 7'b0000000);
                    end
                    default: begin
                        // bit 30 picks srai over srli
                        dec.op  = instr[30] ? exec_pkg::op_sra : exec_pkg::op_srl;
                        dec.in2 = {27'b0, instr[24:20]};
                        legal   = ({funct7[6], funct7[4:0]} == 6'b0);
                    end
                endcase
            end
            // BRANCH, condition only
            7'b1100011: begin
                legal  = 1'b1;
                dec.rd = 5'd0;
                case (funct3)
                    3'd0: dec.op = exec_pkg::op_beq;
                    3'd1: dec.op = exec_pkg::op_bne;
                    3'd4: dec.op = exec_pkg::op_blt;
                    3'd5: dec.op = exec_pkg::op_bge;
                    3'd6: dec.op = exec_pkg::op_bltu;
                    3'd7: dec.op = exec_pkg::op_bgeu;
                    default: legal = 1'b0;
                endcase
            end
            // LUI
            7'b0110111: begin
                legal   = 1'b1;
                dec.op  = exec_pkg::op_lui;
                dec.in2 = imm_u;
            end
            // SYSTEM, only csrrs x0 reads of the counters
            7'b1110011: begin
                legal = (funct3 == 3'b010) && (instr[19:15] == 5'd0);
                case (instr[31:20])
                    exec_pkg::csr_cycle:    dec.op = exec_pkg::op_rdcycle;
                    exec_pkg::csr_cycleh:   dec.op = exec_pkg::op_rdcycleh;
                    exec_pkg::csr_instret:  dec.op = exec_pkg::op_rdinstret;
                    exec_pkg::csr_instreth: dec.op = exec_pkg::op_rdinstreth;
                    default: legal = 1'b0;
                endcase
            end
            default: legal = 1'b0;
        endcase
    end

    // decoded op is payload, strobes are control
    always_ff @(posedge clk) begin
        op <= dec;
        if (!rst_n) begin
            op_write <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            op_write <= instr_valid & legal;
            illegal  <= instr_valid & ~legal;
        end
    end

endmodule

// ==== op_fifo.sv ====
`timescale 1ns/100ps

module op_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  exec_pkg::exec_op_t  push_op,
    input  logic                pop,
    output exec_pkg::exec_op_t  head,
    output logic                full,
    output logic                empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    exec_pkg::exec_op_t mem [FIFO_DEPTH];

    // extra msb is the wrap bit
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign head  = mem[rd_ptr[AW-1:0]];

    // drop pushes when full
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
    input  logic [31:0]        in1,
    input  logic [31:0]        in2,
    input  exec_pkg::alu_op_e  control,
    input  logic [63:0]        instr_cnt,
    input  logic [63:0]        cycle,
    output logic [31:0]        out,
    output logic               zero
);

    // full 64-bit products for the three signedness cases
    logic signed [63:0] prod_ss;
    logic signed [63:0] prod_su;
    logic        [63:0] prod_uu;

    assign prod_ss = $signed({{32{in1[31]}}, in1}) * $signed({{32{in2[31]}}, in2});
    // in2 zero-extended, so it stays unsigned
    assign prod_su = $signed({{32{in1[31]}}, in1}) * $signed({32'b0, in2});
    assign prod_uu = {32'b0, in1} * {32'b0, in2};

    always_comb begin
        out  = 32'd0;
        zero = 1'b0;
        case (control)
            exec_pkg::op_add:  out = in1 + in2;
            exec_pkg::op_sub:  out = in1 - in2;
            // shift amount is in2[4:0]
            exec_pkg::op_sll:  out = in1 << in2[4:0];
            exec_pkg::op_slt:  out = {31'b0, $signed(in1) < $signed(in2)};
            exec_pkg::op_sltu: out = {31'b0, in1 < in2};
            exec_pkg::op_xor:  out = in1 ^ in2;
            exec_pkg::op_srl:  out = in1 >> in2[4:0];
            exec_pkg::op_sra:  out = $signed(in1) >>> in2[4:0];
            exec_pkg::op_or:   out = in1 | in2;
            exec_pkg::op_and:  out = in1 & in2;
            // branch compares, out stays zero
            exec_pkg::op_beq:  zero = (in1 == in2);
            exec_pkg::op_bne:  zero = (in1 != in2);
            exec_pkg::op_blt:  zero = ($signed(in1) < $signed(in2));
            exec_pkg::op_bge:  zero = ($signed(in1) >= $signed(in2));
            exec_pkg::op_bltu: zero = (in1 < in2);
            exec_pkg::op_bgeu: zero = (in1 >= in2);
            exec_pkg::op_lui:  out = in2;
            // low half is the same for any signedness
            exec_pkg::op_mul:    out = prod_uu[31:0];
            exec_pkg::op_mulh:   out = prod_ss[63:32];
            exec_pkg::op_mulhsu: out = prod_su[63:32];
            exec_pkg::op_mulhu:  out = prod_uu[63:32];
            exec_pkg::op_rdinstreth: out = instr_cnt[63:32];
            exec_pkg::op_rdinstret:  out = instr_cnt[31:0];
            exec_pkg::op_rdcycleh:   out = cycle[63:32];
            exec_pkg::op_rdcycle:    out = cycle[31:0];
            default: out = 32'd0;
        endcase
    end

endmodule

// ==== exec_unit.sv ====
`timescale 1ns/100ps

module exec_unit #(
    parameter int MUL_CYCLES = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exec_pkg::exec_op_t     head,
    input  logic                   empty,
    output logic                   pop,
    output logic                   res_valid,
    output exec_pkg::exec_result_t res
);

    localparam int CW = (MUL_CYCLES > 1) ? $clog2(MUL_CYCLES) : 1;

    typedef enum logic {
        st_idle,
        st_mul_wait
    } state_e;

    state_e             state;
    exec_pkg::exec_op_t cur_op;
    logic               cur_valid;
    logic [CW-1:0]      mul_cnt;
    logic [63:0]        cycle_cnt;
    logic [63:0]        instret_cnt;
    logic [31:0]        alu_out;
    logic               alu_zero;
    logic               head_is_mul;
    logic               done;

    assign head_is_mul = (head.op == exec_pkg::op_mul) || (head.op == exec_pkg::op_mulh) ||
                         (head.op == exec_pkg::op_mulhsu) || (head.op == exec_pkg::op_mulhu);

    // held op finishes this cycle
    assign done = cur_valid && (state == st_idle || mul_cnt == '0);
    // refill on the same edge the result is registered
    assign pop  = ~empty && (~cur_valid || done);

    alu alu_inst (
        .in1       (cur_op.in1),
        .in2       (cur_op.in2),
        .control   (cur_op.op),
        .instr_cnt (instret_cnt),
        .cycle     (cycle_cnt),
        .out       (alu_out),
        .zero      (alu_zero)
    );

    // result payload
    always_ff @(posedge clk) begin
        if (done) begin
            res.rd    <= cur_op.rd;
            res.value <= alu_out;
            res.taken <= alu_zero;
        end
        if (pop) begin
            cur_op <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            cur_valid   <= 1'b0;
            mul_cnt     <= '0;
            res_valid   <= 1'b0;
            cycle_cnt   <= 64'd0;
            instret_cnt <= 64'd0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
            res_valid <= done;
            // instret counts strobed results
            if (done) begin
                instret_cnt <= instret_cnt + 64'd1;
            end
            if (pop) begin
                cur_valid <= 1'b1;
                if (head_is_mul) begin
                    state   <= st_mul_wait;
                    mul_cnt <= CW'(MUL_CYCLES - 1);
                end else begin
                    state   <= st_idle;
                    mul_cnt <= '0;
                end
            end else if (done) begin
                cur_valid <= 1'b0;
                state     <= st_idle;
            end else if (state == st_mul_wait) begin
                mul_cnt <= mul_cnt - 1'b1;
            end
        end
    end

endmodule

// ==== exec_top.sv ====
`timescale 1ns/100ps

module exec_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int MUL_CYCLES = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    input  logic [31:0]            rs1_val,
    input  logic [31:0]            rs2_val,
    output logic                   illegal,
    output logic                   full,
    output logic                   res_valid,
    output exec_pkg::exec_result_t res
);

    // decoder to fifo
    logic               op_write;
    exec_pkg::exec_op_t dec_op;
    // fifo to execute unit
    exec_pkg::exec_op_t head;
    logic               empty;
    logic               pop;

    instr_decode instr_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .op_write    (op_write),
        .op          (dec_op),
        .illegal     (illegal)
    );

    op_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) op_fifo_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .push    (op_write),
        .push_op (dec_op),
        .pop     (pop),
        .head    (head),
        .full    (full),
        .empty   (empty)
    );

    exec_unit #(
        .MUL_CYCLES (MUL_CYCLES)
    ) exec_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// ==== exec_assertions.sv ====
`timescale 1ns/100ps

module exec_assertions #(
    parameter int MUL_CYCLES = 3
) (
    input logic               clk,
    input logic               rst_n,
    input logic               op_write,
    input logic               full,
    input logic               pop,
    input logic               empty,
    input logic               illegal,
    input logic               res_valid,
    input exec_pkg::exec_op_t head
);

    // cycles left in which a popped multiply must stay quiet
    int   mul_hold;
    logic head_is_mul;

    assign head_is_mul = (head.op == exec_pkg::op_mul) || (head.op == exec_pkg::op_mulh) ||
                         (head.op == exec_pkg::op_mulhsu) || (head.op == exec_pkg::op_mulhu);

    always @(posedge clk) begin
        if (!rst_n) begin
            mul_hold <= 0;
        end else if (pop && head_is_mul) begin
            mul_hold <= MUL_CYCLES - 1;
        end else if (mul_hold != 0) begin
            mul_hold <= mul_hold - 1;
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(op_write && full))
        else $error("decoder pushed into a full FIFO");

    // an accepted push leaves at least one entry behind
    push_leaves_entry: assert property (@(posedge clk) disable iff (!rst_n)
        op_write && !full |=> !empty)
        else $error("FIFO still empty after an accepted push");

    // no result strobe until the multiply has run its cycles
    mul_result_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        mul_hold != 0 |=> !res_valid)
        else $error("result strobed while a multiply was still running");

    strobes_low_in_reset: assert property (@(posedge clk)
        !rst_n |=> !(op_write || illegal || pop || res_valid))
        else $error("strobe high during reset");

endmodule

bind exec_top exec_assertions #(
    .MUL_CYCLES (MUL_CYCLES)
) exec_assertions_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_write  (op_write),
    .full      (full),
    .pop       (pop),
    .empty     (empty),
    .illegal   (illegal),
    .res_valid (res_valid),
    .head      (head)
);

// ==== tb_exec_top.sv ====
`timescale 1ns/100ps

module tb_exec_top;

    localparam int MUL_CYCLES = 3;
    // instructions sent over all six tests
    localparam int NUM_INSTR  = 189;
    localparam int MAX_CYCLES = NUM_INSTR * (MUL_CYCLES + 3) + 800;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic [31:0]            rs1_val;
    logic [31:0]            rs2_val;
    logic                   illegal;
    logic                   full;
    logic                   res_valid;
    exec_pkg::exec_result_t res;

    // decoded ops still waiting for their result, oldest first
    exec_pkg::exec_op_t pend_q[$];
    logic [31:0]        lcg_state = 32'd80365;
    // mirror of the dut cycle counter
    logic [63:0]        tb_cycle;
    int errors       = 0;
    int checks       = 0;
    int retired      = 0;
    int legal_sent   = 0;
    int illegal_sent = 0;
    int illegal_seen = 0;
    int timer        = 0;

    exec_top exec_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .illegal     (illegal),
        .full        (full),
        .res_valid   (res_valid),
        .res         (res)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // extreme operands, index 3 and up gives a random one
    function automatic logic [31:0] pick(int idx);
        case (idx)
            0: return 32'h8000_0000;
            1: return 32'hFFFF_FFFF;
            2: return 32'h0;
            default: return lcg_next();
        endcase
    endfunction

    function automatic exec_pkg::exec_op_t mk_op(exec_pkg::alu_op_e op, logic [31:0] in1,
            logic [31:0] in2, logic [4:0] rd);
        exec_pkg::exec_op_t o;
        o.op  = op;
        o.in1 = in1;
        o.in2 = in2;
        o.rd  = rd;
        return o;
    endfunction

    // rv32 encoders
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
            logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [2:0] alu_f3(exec_pkg::alu_op_e op);
        case (op)
            exec_pkg::op_sll:  return 3'd1;
            exec_pkg::op_slt:  return 3'd2;
            exec_pkg::op_sltu: return 3'd3;
            exec_pkg::op_xor:  return 3'd4;
            exec_pkg::op_srl:  return 3'd5;
            exec_pkg::op_sra:  return 3'd5;
            exec_pkg::op_or:   return 3'd6;
            exec_pkg::op_and:  return 3'd7;
            default:           return 3'd0;
        endcase
    endfunction

    function automatic logic [11:0] csr_addr(exec_pkg::alu_op_e op);
        case (op)
            exec_pkg::op_rdinstreth: return exec_pkg::csr_instreth;
            exec_pkg::op_rdinstret:  return exec_pkg::csr_instret;
            exec_pkg::op_rdcycleh:   return exec_pkg::csr_cycleh;
            default:                 return exec_pkg::csr_cycle;
        endcase
    endfunction

    // reference model of the operation table
    function automatic exec_pkg::exec_result_t exp_result(exec_pkg::exec_op_t op,
            logic [63:0] cyc, logic [63:0] ret);
        exec_pkg::exec_result_t r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sa;
        logic [31:0] sb;
        logic [63:0] pu;
        a  = op.in1;
        b  = op.in2;
        // sign bit flipped, so unsigned compare acts signed
        sa = a ^ 32'h8000_0000;
        sb = b ^ 32'h8000_0000;
        pu = {32'b0, a} * {32'b0, b};
        r.rd    = op.rd;
        r.value = 32'h0;
        r.taken = 1'b0;
        case (op.op)
            exec_pkg::op_add:  r.value = a + b;
            exec_pkg::op_sub:  r.value = a - b;
            exec_pkg::op_sll:  r.value = a << b[4:0];
            exec_pkg::op_slt:  r.value = {31'b0, sa < sb};
            exec_pkg::op_sltu: r.value = {31'b0, a < b};
            exec_pkg::op_xor:  r.value = a ^ b;
            exec_pkg::op_srl:  r.value = a >> b[4:0];
            exec_pkg::op_sra:  r.value = (a >> b[4:0]) | (a[31] ? ~(32'hFFFF_FFFF >> b[4:0]) : 0);
            exec_pkg::op_or:   r.value = a | b;
            exec_pkg::op_and:  r.value = a & b;
            exec_pkg::op_beq:  r.taken = (a == b);
            exec_pkg::op_bne:  r.taken = (a != b);
            exec_pkg::op_blt:  r.taken = (sa < sb);
            exec_pkg::op_bge:  r.taken = !(sa < sb);
            exec_pkg::op_bltu: r.taken = (a < b);
            exec_pkg::op_bgeu: r.taken = !(a < b);
            exec_pkg::op_lui:  r.value = b;
            exec_pkg::op_mul:  r.value = pu[31:0];
            // signed high halves corrected from the unsigned product
            exec_pkg::op_mulh:   r.value = pu[63:32] - (a[31] ? b : 0) - (b[31] ? a : 0);
            exec_pkg::op_mulhsu: r.value = pu[63:32] - (a[31] ? b : 0);
            exec_pkg::op_mulhu:  r.value = pu[63:32];
            exec_pkg::op_rdinstreth: r.value = ret[63:32];
            exec_pkg::op_rdinstret:  r.value = ret[31:0];
            exec_pkg::op_rdcycleh:   r.value = cyc[63:32];
            default:                 r.value = cyc[31:0];
        endcase
        return r;
    endfunction

    // one strobe, called 2 ns after an edge, returns 2 ns after the sampling edge
    task automatic send(logic [31:0] word, logic [31:0] a, logic [31:0] b,
            exec_pkg::exec_op_t exp_op, logic legal);
        if (full) begin
            $display("[ERROR] %0t: strobe attempted while the FIFO is full", $time);
            errors++;
        end
        instr_valid = 1'b1;
        instr       = word;
        rs1_val     = a;
        rs2_val     = b;
        if (legal) begin
            pend_q.push_back(exp_op);
            legal_sent++;
        end else begin
            illegal_sent++;
        end
        @(posedge clk);
        #2;
        instr_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (pend_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    task automatic finish_test(string name, int err_start);
        wait_idle();
        $display("test %s: %0d errors", name, errors - err_start);
    endtask

    // edges after the sampling edge until res_valid shows
    task automatic count_latency(output int lat);
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!res_valid && lat < 20);
        #1;
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            tb_cycle <= 64'd0;
        end else begin
            tb_cycle <= tb_cycle + 64'd1;
        end
    end

    always @(posedge clk) begin
        timer++;
        if (timer >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // scoreboard, sampled 1 ns after each edge
    always begin
        exec_pkg::exec_op_t     op;
        exec_pkg::exec_result_t exp;
        @(posedge clk);
        #1;
        if (rst_n && illegal) begin
            illegal_seen++;
        end
        if (rst_n && res_valid) begin
            if (pend_q.size() == 0) begin
                $display("result for rd %0d arrived with no instruction pending", res.rd);
                errors++;
            end else begin
                op = pend_q.pop_front();
                // counter reads see the cycle before the strobe
                exp = exp_result(op, tb_cycle - 64'd1, 64'(retired));
                checks++;
                if (res.rd != exp.rd) begin
                    $display("[ERROR] %0t: %s rd %0d, expected %0d", $time, op.op.name(),
                             res.rd, exp.rd);
                    errors++;
                end
                if (res.value != exp.value) begin
                    $display("[ERROR] %0t: %s value %h, expected %h", $time, op.op.name(),
                             res.value, exp.value);
                    errors++;
                end
                if (res.taken != exp.taken) begin
                    $display("[ERROR] %0t: %s taken %b, expected %b", $time, op.op.name(),
                             res.taken, exp.taken);
                    errors++;
                end
            end
            retired++;
        end
    end

    initial begin
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       r;
        logic [31:0]       b_imm;
        logic [11:0]       imm;
        logic [6:0]        f7;
        logic [2:0]        f3;
        logic [4:0]        rd;
        exec_pkg::alu_op_e op;
        int                k;
        int                lat;
        int                err0;
        logic [31:0]       bad [3];
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'h0;
        rs1_val     = 32'h0;
        rs2_val     = 32'h0;
        // lw, auipc, csrrs of mstatus
        bad[0] = {12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011};
        bad[1] = {20'h12345, 5'd3, 7'b0010111};
        bad[2] = {12'h300, 5'd0, 3'b010, 5'd3, 7'b1110011};
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // alternating r-type and i-type alu ops
        err0 = errors;
        for (int i = 0; i < 60; i++) begin
            a  = lcg_next();
            b  = lcg_next();
            r  = lcg_next();
            op = exec_pkg::alu_op_e'(5'(r % 10));
            rd = r[15:11];
            if (i % 2 == 0) begin
                f7 = (op == exec_pkg::op_sub || op == exec_pkg::op_sra) ? 7'h20 : 7'h00;
                send(enc_r(f7, alu_f3(op), rd), a, b, mk_op(op, a, b, rd), 1'b1);
            end else begin
                if (op == exec_pkg::op_sub) begin
                    op = exec_pkg::op_add;
                end
                if (op == exec_pkg::op_sll || op == exec_pkg::op_srl || op == exec_pkg::op_sra) begin
                    imm   = {(op == exec_pkg::op_sra) ? 7'h20 : 7'h00, r[24:20]};
                    b_imm = {27'b0, r[24:20]};
                end else begin
                    imm   = r[31:20];
                    b_imm = {{20{imm[11]}}, imm};
                end
                send(enc_i(imm, 5'd1, alu_f3(op), rd, 7'b0010011), a, b,
                     mk_op(op, a, b_imm, rd), 1'b1);
            end
        end
        finish_test("arith_logic", err0);

        // branch conditions, equal operands every other one
        err0 = errors;
        for (int i = 0; i < 40; i++) begin
            a  = lcg_next();
            b  = (i % 2 == 0) ? a : lcg_next();
            r  = lcg_next();
            k  = r[18:16] % 6;
            op = exec_pkg::alu_op_e'(5'(10 + k));
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            send({7'b0, 5'd2, 5'd1, f3, 5'd0, 7'b1100011}, a, b, mk_op(op, a, b, 5'd0), 1'b1);
        end
        finish_test("branch", err0);

        // lui, then bursts of all four multiplies over extreme operand pairs
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            r = lcg_next();
            send({r[31:12], r[11:7], 7'b0110111}, 32'h0, 32'h0,
                 mk_op(exec_pkg::op_lui, 32'h0, {r[31:12], 12'b0}, r[11:7]), 1'b1);
        end
        for (int j = 0; j < 16; j++) begin
            a = pick(j / 4);
            b = pick(j % 4);
            for (int f = 0; f < 4; f++) begin
                op = exec_pkg::alu_op_e'(5'(17 + f));
                send(enc_r(7'h01, 3'(f), 5'(j + 1)), a, b, mk_op(op, a, b, 5'(j + 1)), 1'b1);
            end
            wait_idle();
        end
        finish_test("lui_mul", err0);

        // counter reads between adds, with idle gaps
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            a  = lcg_next();
            b  = lcg_next();
            send(enc_r(7'h00, 3'd0, 5'd5), a, b, mk_op(exec_pkg::op_add, a, b, 5'd5), 1'b1);
            op = exec_pkg::alu_op_e'(5'(21 + i % 4));
            send(enc_i(csr_addr(op), 5'd0, 3'b010, 5'd6, 7'b1110011), a, b,
                 mk_op(op, a, b, 5'd6), 1'b1);
            repeat (i % 3) begin
                @(posedge clk);
                #2;
            end
        end
        finish_test("counters", err0);

        // illegal encodings enqueue nothing
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            send(bad[i], 32'h0, 32'h0, mk_op(exec_pkg::op_add, 32'h0, 32'h0, 5'd0), 1'b0);
            if (!illegal) begin
                $display("illegal did not pulse after instruction %h", bad[i]);
                errors++;
            end
            @(posedge clk);
            #2;
            if (illegal) begin
                $display("illegal stayed high longer than one cycle after %h", bad[i]);
                errors++;
            end
        end
        wait_idle();
        if (retired != legal_sent) begin
            $display("%0d results seen for %0d legal instructions", retired, legal_sent);
            errors++;
        end
        if (illegal_seen != illegal_sent) begin
            $display("%0d illegal pulses seen for %0d illegal instructions",
                     illegal_seen, illegal_sent);
            errors++;
        end
        finish_test("illegal", err0);

        // latency with an empty pipeline
        err0 = errors;
        a = lcg_next();
        b = lcg_next();
        send(enc_r(7'h00, 3'd0, 5'd7), a, b, mk_op(exec_pkg::op_add, a, b, 5'd7), 1'b1);
        count_latency(lat);
        if (lat != 3) begin
            $display("[ERROR] %0t: add latency %0d edges, expected 3", $time, lat);
            errors++;
        end
        wait_idle();
        send(enc_r(7'h01, 3'd0, 5'd8), a, b, mk_op(exec_pkg::op_mul, a, b, 5'd8), 1'b1);
        count_latency(lat);
        if (lat != 2 + MUL_CYCLES) begin
            $display("[ERROR] %0t: mul latency %0d edges, expected %0d", $time, lat,
                     2 + MUL_CYCLES);
            errors++;
        end
        finish_test("latency", err0);

        $display("total: %0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
exec_pkg.sv
instr_decode.sv
op_fifo.sv
alu.sv
exec_unit.sv
exec_top.sv
exec_assertions.sv
tb_exec_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the exec_top testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module tb_exec_top \
        -f filelist.f -o sim_tb_exec_top; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/sim_tb_exec_top 2>&1); then
    echo "$output"
    echo "simulation exited with a failing status"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
